// ==== logic/isa_pkg.sv ====
package isa_pkg;

	typedef logic [31:0] instr_t;

	// instruction field positions
	localparam int OPC_LSB  = 0;
	localparam int OPC_MSB  = 6;
	localparam int V_BIT    = 7;   // vector flag
	localparam int OVF_BIT  = 8;   // add overflow check
	localparam int FUNC_LSB = 9;
	localparam int FUNC_MSB = 13;

	typedef enum logic [6:0] {
		R1    = 7'h01,
		R2    = 7'h02,
		BTFLD = 7'h03,
		ADDI  = 7'h04,
		SUBFI = 7'h05,
		ANDI  = 7'h08,
		ORI   = 7'h09,
		XORI  = 7'h0A,
		CMPI  = 7'h0B,
		SEQI  = 7'h0C,
		SNEI  = 7'h0D,
		SLTI  = 7'h0E
	} opcode_e;

	typedef enum logic [4:0] {
		ABS    = 5'd0,
		V2BITS = 5'd1,
		BITS2V = 5'd2
	} r1_func_e;

	typedef enum logic [4:0] {
		ADD  = 5'd0,
		SUBF = 5'd1,
		AND  = 5'd2,
		OR   = 5'd3,
		XOR  = 5'd4,
		ORC  = 5'd5,
		NAND = 5'd6,
		NOR  = 5'd7,
		XNOR = 5'd8,
		ANDC = 5'd9,
		CMP  = 5'd10,
		SLL  = 5'd11,
		SRL  = 5'd12,
		SRA  = 5'd13,
		ROL  = 5'd14,
		ROR  = 5'd15,
		SEQ  = 5'd16,
		SNE  = 5'd17,
		SLT  = 5'd18,
		SGE  = 5'd19,
		SLTU = 5'd20,
		SGEU = 5'd21,
		MIN  = 5'd22,
		MAX  = 5'd23
	} r2_func_e;

	typedef enum logic [4:0] {
		EXTU = 5'd0,
		EXTS = 5'd1,
		CLR  = 5'd2,
		SET  = 5'd3
	} bf_func_e;

endpackage

// ==== logic/alu_pkg.sv ====
package alu_pkg;

	localparam int LANES  = 2;
	localparam int LANE_W = 64;
	localparam int VEC_W  = LANES * LANE_W;

	typedef logic [LANE_W-1:0] lane_t;
	typedef logic [VEC_W-1:0]  vec_t;
	typedef logic [LANES-1:0]  mask_t;   // one predicate bit per lane
	typedef logic [5:0]        step_t;

	// fault cause codes
	typedef enum logic [7:0] {
		FLT_NONE = 8'h00,
		FLT_OFL  = 8'h21
	} fault_e;

endpackage

// ==== logic/alu_req_if.sv ====
`timescale 1ns/1ns

interface alu_req_if
	import isa_pkg::*;
	import alu_pkg::*;
();

	instr_t ir;
	step_t  step;
	mask_t  mask;
	logic   zero;   // clear inactive lanes
	vec_t   a;
	vec_t   b;
	vec_t   c;
	vec_t   t;      // old target value
	lane_t  imm;

	modport stage
	(
		output ir, step, mask, zero, a, b, c, t, imm
	);

	modport lane
	(
		input ir, step, mask, zero, a, b, c, t, imm
	);

endinterface

// ==== logic/bitfield_unit.sv ====
`timescale 1ns/1ns

module bitfield_unit
	import isa_pkg::*;
	import alu_pkg::*;
(
	input  bf_func_e func,
	input  lane_t    a,
	input  step_t    offset,
	input  step_t    width_m1,
	output lane_t    o
);

	lane_t wmask;   // field ones at bit 0
	lane_t fmask;   // field ones at offset
	lane_t extu;
	lane_t exts;

	// width_m1+1 ones
	assign wmask = {LANE_W{1'b1}} >> (6'd63 - width_m1);

	// bits shifted past 63 fall away
	assign fmask = wmask << offset;

	assign extu = (a >> offset) & wmask;

	always_comb
	begin
		exts = extu;
		if (extu[width_m1])
			exts = extu | ~wmask;   // replicate field msb
	end

	always_comb
	begin
		case (func)
		EXTU:
			o = extu;
		EXTS:
			o = exts;
		CLR:
			o = a & ~fmask;
		SET:
			o = a | fmask;
		default:
			o = '0;
		endcase
	end

endmodule

// ==== logic/alu_lane.sv ====
`timescale 1ns/1ns

module alu_lane
	import isa_pkg::*;
	import alu_pkg::*;
#(
	parameter int LANE_IDX = 0
)
(
	alu_req_if.lane req,
	output lane_t   o,
	output fault_e  cause
);

	opcode_e      opc;
	logic [4:0]   fn;
	lane_t        a;
	lane_t        b;
	lane_t        c;
	lane_t        t;
	logic         active;
	logic         known;
	lane_t        o1;
	lane_t        sum;
	logic [64:0]  wsum;
	lane_t        bfldo;
	logic [127:0] sllo;
	logic [127:0] srlo;
	lane_t        srao;

	assign opc = opcode_e'(req.ir[OPC_MSB:OPC_LSB]);
	assign fn  = req.ir[FUNC_MSB:FUNC_LSB];

	assign a = req.a[LANE_IDX*LANE_W +: LANE_W];
	assign b = req.b[LANE_IDX*LANE_W +: LANE_W];
	assign c = req.c[LANE_IDX*LANE_W +: LANE_W];
	assign t = req.t[LANE_IDX*LANE_W +: LANE_W];

	// scalar ops ignore the mask
	assign active = req.mask[LANE_IDX] | ~req.ir[V_BIT];

	assign sum  = a + b;
	assign wsum = {a[63], a} + {b[63], b};   // sign-extended sum
	assign sllo = {64'd0, a} << b[5:0];
	assign srlo = {a, 64'd0} >> b[5:0];
	assign srao = $signed(a) >>> b[5:0];

	// signed three-way compare
	function automatic lane_t cmp3(lane_t x, lane_t y);
		if ($signed(x) < $signed(y))
			return '1;
		else if (x == y)
			return '0;
		else
			return lane_t'(1);
	endfunction

	bitfield_unit u_bfld
	(
		.func     (bf_func_e'(fn)),
		.a        (a),
		.offset   (step_t'(b[5:0])),
		.width_m1 (step_t'(c[5:0])),
		.o        (bfldo)
	);

	always_comb
	begin
		known = 1'b1;
		o1 = '0;
		case (opc)
		R1:
			case (r1_func_e'(fn))
			ABS:	o1 = $signed(a) < 0 ? -a : a;
			V2BITS:
				if (req.step == 6'd0)
					o1 = lane_t'(a[0]);
				else
				begin
					o1 = t;
					o1[req.step] = a[0];   // replace one bit of t
				end
			BITS2V:	o1 = lane_t'(a[req.step]);
			default:	known = 1'b0;
			endcase
		R2:
			case (r2_func_e'(fn))
			ADD:	o1 = sum;
			SUBF:	o1 = b - a;
			AND:	o1 = a & b;
			OR:		o1 = a | b;
			XOR:	o1 = a ^ b;
			ORC:	o1 = a | ~b;
			NAND:	o1 = ~(a & b);
			NOR:	o1 = ~(a | b);
			XNOR:	o1 = ~(a ^ b);
			ANDC:	o1 = a & ~b;
			CMP:	o1 = cmp3(a, b);
			SLL:	o1 = sllo[63:0];
			SRL:	o1 = srlo[127:64];
			SRA:	o1 = srao;
			ROL:	o1 = sllo[63:0] | sllo[127:64];
			ROR:	o1 = srlo[127:64] | srlo[63:0];
			SEQ:	o1 = lane_t'(a == b);
			SNE:	o1 = lane_t'(a != b);
			SLT:	o1 = lane_t'($signed(a) < $signed(b));
			SGE:	o1 = lane_t'($signed(a) >= $signed(b));
			SLTU:	o1 = lane_t'(a < b);
			SGEU:	o1 = lane_t'(a >= b);
			MIN:	o1 = $signed(a) < $signed(b) ? a : b;
			MAX:	o1 = $signed(a) > $signed(b) ? a : b;
			default:	known = 1'b0;
			endcase
		ADDI:	o1 = a + req.imm;
		SUBFI:	o1 = req.imm - a;
		ANDI:	o1 = a & req.imm;
		ORI:	o1 = a | req.imm;
		XORI:	o1 = a ^ req.imm;
		CMPI:	o1 = cmp3(a, req.imm);
		SEQI:	o1 = lane_t'(a == req.imm);
		SNEI:	o1 = lane_t'(a != req.imm);
		SLTI:	o1 = lane_t'($signed(a) < $signed(req.imm));
		BTFLD:
			if (fn > 5'd3)
				known = 1'b0;
			else
				o1 = bfldo;
		default:	known = 1'b0;
		endcase
	end

	// masking of inactive lanes
	always_comb
	begin
		if (!known)
			o = '0;
		else if (active)
			o = o1;
		else if (req.zero)
			o = '0;
		else
			o = t;
	end

	always_comb
	begin
		cause = FLT_NONE;
		if (active && opc == R2 && r2_func_e'(fn) == ADD && req.ir[OVF_BIT])
			if (a[63] == b[63] && sum[63] != a[63])   // same signs in, other sign out
				cause = FLT_OFL;
	end

	always_comb
	begin
		if (cause == FLT_OFL)
			assert final (opc == R2 && r2_func_e'(fn) == ADD && wsum[64] != wsum[63])
			else $error("overflow fault without add overflow in lane %0d", LANE_IDX);
	end

endmodule

// ==== logic/alu_exec_stage.sv ====
`timescale 1ns/1ns

module alu_exec_stage
	import isa_pkg::*;
	import alu_pkg::*;
(
	input  logic   clk,
	input  logic   rst_n,
	input  logic   in_valid,
	input  instr_t ir,
	input  step_t  step,
	input  mask_t  mask,
	input  logic   zero,
	input  vec_t   a,
	input  vec_t   b,
	input  vec_t   c,
	input  vec_t   t,
	input  lane_t  imm,
	output logic   out_valid,
	output vec_t   result,
	output fault_e cause
);

	alu_req_if req ();

	logic   req_valid;
	vec_t   lane_o;
	fault_e lane_cause [LANES];
	fault_e red_cause;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			req_valid <= 1'b0;
		else
			req_valid <= in_valid;
	end

	// payload loads only on a new request
	always_ff @(posedge clk)
	begin
		if (in_valid)
		begin
			req.ir   <= ir;
			req.step <= step;
			req.mask <= mask;
			req.zero <= zero;
			req.a    <= a;
			req.b    <= b;
			req.c    <= c;
			req.t    <= t;
			req.imm  <= imm;
		end
	end

	genvar g;
	generate
		for (g = 0; g < LANES; g = g + 1)
		begin : g_lane
			alu_lane #(.LANE_IDX(g)) u_lane
			(
				.req   (req),
				.o     (lane_o[g*LANE_W +: LANE_W]),
				.cause (lane_cause[g])
			);
		end
	endgenerate

	always_comb
	begin
		red_cause = FLT_NONE;
		for (int i = 0; i < LANES; i++)
			if (lane_cause[i] == FLT_OFL)
				red_cause = FLT_OFL;
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			out_valid <= 1'b0;
			cause     <= FLT_NONE;
		end
		else
		begin
			out_valid <= req_valid;
			cause     <= req_valid ? red_cause : FLT_NONE;
		end
	end

	always_ff @(posedge clk)
	begin
		if (req_valid)
			result <= lane_o;
	end

	assert property (@(posedge clk) disable iff (!rst_n) !$isunknown(out_valid))
	else $error("out_valid unknown");

	assert property (@(posedge clk) disable iff (!rst_n) !out_valid |-> cause == FLT_NONE)
	else $error("cause set without out_valid");

endmodule

// ==== logic/alu_top.sv ====
`timescale 1ns/1ns

module alu_top
	import isa_pkg::*;
	import alu_pkg::*;
(
	input  logic   clk,
	input  logic   rst_n,
	input  logic   in_valid,
	input  instr_t ir,
	input  step_t  step,
	input  mask_t  mask,
	input  logic   zero,
	input  vec_t   a,
	input  vec_t   b,
	input  vec_t   c,
	input  vec_t   t,
	input  lane_t  imm,
	output logic   out_valid,
	output vec_t   result,
	output fault_e cause
);

	alu_exec_stage u_exec
	(
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.ir        (ir),
		.step      (step),
		.mask      (mask),
		.zero      (zero),
		.a         (a),
		.b         (b),
		.c         (c),
		.t         (t),
		.imm       (imm),
		.out_valid (out_valid),
		.result    (result),
		.cause     (cause)
	);

endmodule

// ==== sim/alu_ref.svh ====
`ifndef ALU_REF_SVH
`define ALU_REF_SVH

// expected lane result with its cause in flt
function automatic lane_t alu_ref_lane(input instr_t ir_w, input step_t st, input logic m,
	input logic zr, input lane_t a_l, input lane_t b_l, input lane_t c_l, input lane_t t_l,
	input lane_t imm_l, output fault_e flt);
	logic [6:0] opc;
	logic [4:0] fn;
	logic [4:0] f;
	logic       act;
	logic       ok;
	lane_t      y;
	lane_t      r;
	lane_t      fld;
	lane_t      fm;
	lane_t      s;
	int         sh;
	int         off;
	int         wd;
	int         i;
	opc = ir_w[OPC_MSB:OPC_LSB];
	fn = ir_w[FUNC_MSB:FUNC_LSB];
	act = m | ~ir_w[V_BIT];
	y = (opc == R2) ? b_l : imm_l;   // second operand
	sh = y[5:0];
	off = b_l[5:0];
	wd = c_l[5:0] + 1;
	s = a_l + b_l;
	ok = 1'b1;
	r = '0;
	flt = FLT_NONE;

	// immediate forms behave like their register twins
	f = 5'd31;
	case (opc)
	R2:	f = fn;
	ADDI:	f = ADD;
	SUBFI:	f = SUBF;
	ANDI:	f = AND;
	ORI:	f = OR;
	XORI:	f = XOR;
	CMPI:	f = CMP;
	SEQI:	f = SEQ;
	SNEI:	f = SNE;
	SLTI:	f = SLT;
	default:	f = 5'd31;
	endcase

	case (opc)
	R1:
		case (fn)
		ABS:	r = a_l[63] ? 64'd0 - a_l : a_l;
		V2BITS:
		begin
			r = (st == 6'd0) ? '0 : t_l;
			r[st] = a_l[0];
		end
		BITS2V:	r = lane_t'(a_l[st]);
		default:	ok = 1'b0;
		endcase
	BTFLD:
	begin
		fld = '0;
		fm = '0;
		for (i = 0; i < wd; i++)
			if (off + i < 64)
			begin
				fld[i] = a_l[off + i];
				fm[off + i] = 1'b1;
			end
		case (fn)
		EXTU:	r = fld;
		EXTS:	r = fld[wd - 1] ? fld | ~((lane_t'(1) << wd) - 64'd1) : fld;
		CLR:	r = a_l & ~fm;
		SET:	r = a_l | fm;
		default:	ok = 1'b0;
		endcase
	end
	default:
		case (f)
		ADD:	r = a_l + y;
		SUBF:	r = y - a_l;
		AND:	r = a_l & y;
		OR:	r = a_l | y;
		XOR:	r = a_l ^ y;
		ORC:	r = a_l | ~y;
		NAND:	r = ~(a_l & y);
		NOR:	r = ~(a_l | y);
		XNOR:	r = ~(a_l ^ y);
		ANDC:	r = a_l & ~y;
		CMP:	r = ($signed(a_l) < $signed(y)) ? {LANE_W{1'b1}} : ((a_l == y) ? '0 : 64'd1);
		SLL:	r = a_l << sh;
		SRL:	r = a_l >> sh;
		SRA:	r = lane_t'($signed(a_l) >>> sh);
		ROL:	r = (sh == 0) ? a_l : (a_l << sh) | (a_l >> (64 - sh));
		ROR:	r = (sh == 0) ? a_l : (a_l >> sh) | (a_l << (64 - sh));
		SEQ:	r = lane_t'(a_l == y);
		SNE:	r = lane_t'(a_l != y);
		SLT:	r = lane_t'($signed(a_l) < $signed(y));
		SGE:	r = lane_t'($signed(a_l) >= $signed(y));
		SLTU:	r = lane_t'(a_l < y);
		SGEU:	r = lane_t'(a_l >= y);
		MIN:	r = ($signed(a_l) < $signed(y)) ? a_l : y;
		MAX:	r = ($signed(a_l) > $signed(y)) ? a_l : y;
		default:	ok = 1'b0;   // also unknown opcodes
		endcase
	endcase

	if (!ok)
		r = '0;
	else if (!act)
		r = zr ? '0 : t_l;
	if (act && opc == R2 && fn == ADD && ir_w[OVF_BIT] && a_l[63] == b_l[63]
		&& s[63] != a_l[63])
		flt = FLT_OFL;
	return r;
endfunction

`endif

// ==== sim/alu_tb.sv ====
`timescale 1ns/1ns

module alu_tb
	import isa_pkg::*;
	import alu_pkg::*;
();

	logic   clk;
	logic   rst_n;
	logic   in_valid;
	instr_t ir;
	step_t  step;
	mask_t  mask;
	logic   zero;
	vec_t   a;
	vec_t   b;
	vec_t   c;
	vec_t   t;
	lane_t  imm;
	logic   out_valid;
	vec_t   result;
	fault_e cause;

	vec_t   exp_res [$];
	fault_e exp_cause [$];
	vec_t   last_exp;
	int     seed = 69784;
	int     errors = 0;
	int     mark = 0;
	int     ntests = 0;
	int     issued = 0;
	int     seen = 0;

	opcode_e imm_ops [9] = '{ADDI, SUBFI, ANDI, ORI, XORI, CMPI, SEQI, SNEI, SLTI};

	// pairs 0, 1, 4 and 5 overflow
	lane_t ovf_a [6] = '{64'h7fff_ffff_ffff_ffff, 64'h8000_0000_0000_0000, 64'h1,
		64'h7fff_ffff_ffff_ffff, 64'hffff_ffff_ffff_ffff, 64'h4000_0000_0000_0000};
	lane_t ovf_b [6] = '{64'h1, 64'h8000_0000_0000_0000, 64'h1,
		64'hffff_ffff_ffff_ffff, 64'h8000_0000_0000_0000, 64'h4000_0000_0000_0000};

	`include "alu_ref.svh"

	alu_top dut (.*);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic lane_t rnd64();
		return {$random(seed), $random(seed)};
	endfunction

	function automatic vec_t rndv();
		return {rnd64(), rnd64()};
	endfunction

	function automatic instr_t make_ir(logic [6:0] op, logic [4:0] fn, logic v, logic ovf);
		instr_t w;
		w = '0;
		w[OPC_MSB:OPC_LSB] = op;
		w[V_BIT] = v;
		w[OVF_BIT] = ovf;
		w[FUNC_MSB:FUNC_LSB] = fn;
		return w;
	endfunction

	task automatic check_vec(string name, vec_t got, vec_t exp);
		if (got !== exp)
		begin
			$display("error %s: got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_fault(string name, fault_e got, fault_e exp);
		if (got !== exp)
		begin
			$display("error %s: got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic issue(instr_t i_ir, step_t i_st, mask_t i_m, logic i_z, vec_t i_a,
		vec_t i_b, vec_t i_c, vec_t i_t, lane_t i_imm);
		vec_t   er;
		fault_e ec;
		fault_e lc;
		ec = FLT_NONE;
		for (int l = 0; l < LANES; l++)
		begin
			er[l*LANE_W +: LANE_W] = alu_ref_lane(i_ir, i_st, i_m[l], i_z,
				i_a[l*LANE_W +: LANE_W], i_b[l*LANE_W +: LANE_W], i_c[l*LANE_W +: LANE_W],
				i_t[l*LANE_W +: LANE_W], i_imm, lc);
			if (lc == FLT_OFL)
				ec = FLT_OFL;
		end
		@(negedge clk);
		in_valid = 1'b1;
		ir = i_ir;
		step = i_st;
		mask = i_m;
		zero = i_z;
		a = i_a;
		b = i_b;
		c = i_c;
		t = i_t;
		imm = i_imm;
		exp_res.push_back(er);
		exp_cause.push_back(ec);
		last_exp = er;
		issued++;
	endtask

	task automatic report(string name);
		$display("test %-14s %0d errors", name, errors - mark);
		mark = errors;
		ntests++;
	endtask

	// stop issuing and wait for the pending results
	task automatic end_test(string name);
		int n;
		@(negedge clk);
		in_valid = 1'b0;
		n = 0;
		while (exp_res.size() > 0 && n < 20)
		begin
			@(negedge clk);
			n++;
		end
		if (exp_res.size() > 0)
		begin
			$display("timeout: %0d results missing after 20 cycles", exp_res.size());
			errors += exp_res.size();
			exp_res.delete();
			exp_cause.delete();
		end
		report(name);
	endtask

	// outputs are stable at the falling edge
	initial
	begin
		forever
		begin
			@(negedge clk);
			if (out_valid === 1'b1)
			begin
				seen++;
				if (exp_res.size() == 0)
				begin
					$display("out_valid pulse with no request pending");
					errors++;
				end
				else
				begin
					check_vec("result", result, exp_res.pop_front());
					check_fault("cause", cause, exp_cause.pop_front());
				end
			end
		end
	end

	initial
	begin
		int     k;
		int     l;
		vec_t   av;
		vec_t   bv;
		vec_t   carry;
		instr_t iw;
		rst_n = 1'b0;
		in_valid = 1'b0;
		ir = '0;
		step = '0;
		mask = '0;
		zero = 1'b0;
		a = '0;
		b = '0;
		c = '0;
		t = '0;
		imm = '0;
		repeat (10) @(negedge clk);
		rst_n = 1'b1;

		for (k = 0; k < 5; k++)
		begin
			@(negedge clk);
			if (out_valid !== 1'b0)
			begin
				$display("out_valid not low after reset before any request");
				errors++;
			end
		end
		report("reset_idle");

		for (k = 0; k < 200; k++)
		begin
			if (k % 2 == 0)
				iw = make_ir(R2, 5'($unsigned($random(seed)) % 24), 1'b0, 1'($random(seed)));
			else
				iw = make_ir(imm_ops[$unsigned($random(seed)) % 9], 5'd0, 1'b0, 1'b0);
			av = rndv();
			bv = (k % 5 == 2) ? av : rndv();   // equal operands now and then
			issue(iw, 6'd0, mask_t'($random(seed)), 1'b0, av, bv, rndv(), rndv(), rnd64());
		end
		end_test("scalar_ops");

		for (l = 0; l < LANES; l++)
			for (k = 0; k < 12; k++)
			begin
				av = {LANES{64'd7}};
				bv = {LANES{64'd9}};
				av[l*LANE_W +: LANE_W] = ovf_a[k % 6];
				bv[l*LANE_W +: LANE_W] = ovf_b[k % 6];
				issue(make_ir(R2, ADD, k >= 6, 1'b1), 6'd0, mask_t'($random(seed)), 1'b0,
					av, bv, '0, '0, '0);
			end
		end_test("add_overflow");

		for (k = 0; k < 120; k++)
		begin
			if (k % 2 == 0)
				iw = make_ir(R2, 5'($unsigned($random(seed)) % 24), 1'b1, 1'b1);
			else
				iw = make_ir(imm_ops[$unsigned($random(seed)) % 9], 5'd0, 1'b1, 1'b0);
			issue(iw, 6'd0, mask_t'($random(seed)), 1'($random(seed)), rndv(), rndv(), rndv(),
				rndv(), rnd64());
		end
		end_test("vector_mask");

		for (k = 0; k < 120; k++)
		begin
			bv = rndv();
			if (k % 3 == 0)
				bv[5:0] = 6'd56 + 6'($unsigned($random(seed)) % 8);   // field past bit 63
			issue(make_ir(BTFLD, 5'(k % 4), 1'($random(seed)), 1'b0), 6'd0,
				mask_t'($random(seed)), 1'($random(seed)), rndv(), bv, rndv(), rndv(), '0);
		end
		end_test("bitfield");

		carry = rndv();
		for (k = 0; k < 64; k++)
		begin
			issue(make_ir(R1, V2BITS, 1'b0, 1'b0), step_t'(k), '0, 1'b0, rndv(), '0, '0,
				carry, '0);
			carry = last_exp;   // t for the next step
		end
		av = rndv();
		for (k = 0; k < 64; k++)
			issue(make_ir(R1, BITS2V, 1'b0, 1'b0), step_t'(k), '0, 1'b0, av, '0, '0, carry, '0);
		for (k = 0; k < 64; k++)
		begin
			av = rndv();
			if (k % 8 == 0)
				av[63:0] = 64'h8000_0000_0000_0000;
			issue(make_ir(R1, ABS, 1'b0, 1'b0), step_t'(k), '0, 1'b0, av, '0, '0, rndv(), '0);
		end
		end_test("unary_ops");

		if (seen != issued)
		begin
			$display("result count differs from request count");
			errors++;
		end
		$display("%0d tests, %0d requests, %0d results, %0d errors", ntests, issued, seen, errors);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

// ==== all.f ====
+incdir+sim
logic/isa_pkg.sv
logic/alu_pkg.sv
logic/alu_req_if.sv
logic/bitfield_unit.sv
logic/alu_lane.sv
logic/alu_exec_stage.sv
logic/alu_top.sv
sim/alu_tb.sv

// ==== run.sh ====
#!/bin/bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f all.f --top-module alu_tb -o alu_sim \
	&& ./obj_dir/alu_sim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "TESTBENCH PASSED" sim.log && exit 0 || exit 1
